/* source/minerPkg.sv */
package minerPkg;

    // Block header split
    // 80 byte header, last 4 bytes are the nonce
    localparam int headerPrefixBits = 608;
    localparam int nonceBits = 32;

    // Digest and target width
    localparam int hashBits = 256;

    // System clocks per mining strobe
    // Stands in for the slower mining clock of the old wrapper
    localparam int mineDivide = 3;

    // Header bytes 0 to 75, byte 0 in the top bits
    typedef logic [headerPrefixBits-1:0] headerPrefixT;

    // Nonce appended as raw header bytes 76 to 79
    typedef logic [nonceBits-1:0] nonceT;

    // Double hash digest, also used for the target
    // Target is compared against the byte reversed digest
    typedef logic [hashBits-1:0] hashT;

endpackage

/* source/sha256Pkg.sv */
package sha256Pkg;

    // Basic SHA-256 word
    typedef logic [31:0] wordT;

    // Message block, word 0 in the top bits
    typedef wordT [0:15] blockT;

    // Chaining value, index 0 is H0 or working variable a
    typedef wordT [0:7] stateT;

    // Round constants K0 to K63
    localparam wordT roundConst [0:63] = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    // Initial hash value H0 to H7
    localparam stateT initialState = {
        32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
        32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
    };

    // Rotations written as concatenations
    // rotr 2, 13, 22
    function automatic wordT bigSigma0(input wordT x);
        return {x[1:0], x[31:2]} ^ {x[12:0], x[31:13]} ^ {x[21:0], x[31:22]};
    endfunction

    // rotr 6, 11, 25
    function automatic wordT bigSigma1(input wordT x);
        return {x[5:0], x[31:6]} ^ {x[10:0], x[31:11]} ^ {x[24:0], x[31:25]};
    endfunction

    // rotr 7, 18, shr 3
    function automatic wordT smallSigma0(input wordT x);
        return {x[6:0], x[31:7]} ^ {x[17:0], x[31:18]} ^ (x >> 3);
    endfunction

    // rotr 17, 19, shr 10
    function automatic wordT smallSigma1(input wordT x);
        return {x[16:0], x[31:17]} ^ {x[18:0], x[31:19]} ^ (x >> 10);
    endfunction

    // e selects between f and g
    function automatic wordT choose(input wordT e, input wordT f, input wordT g);
        return (e & f) ^ (~e & g);
    endfunction

    // Bitwise vote of a, b, c
    function automatic wordT majority(input wordT a, input wordT b, input wordT c);
        return (a & b) ^ (a & c) ^ (b & c);
    endfunction

endpackage

/* source/mineTickGen.sv */
`timescale 1ns/10ps

module mineTickGen (
    input  logic clock,
    input  logic rstN,
    output logic mineTick
);
    import minerPkg::*;

    // Just wide enough for 0 to mineDivide-1
    typedef logic [$clog2(mineDivide)-1:0] countT;

    countT count;

    // Free running modulo counter
    // Strobe is registered, one clock wide
    always_ff @(posedge clock) begin
        if (!rstN) begin
            count <= '0;
            mineTick <= 1'b0;
        end else if (count == countT'(mineDivide - 1)) begin
            count <= '0;
            mineTick <= 1'b1;
        end else begin
            count <= count + countT'(1);
            mineTick <= 1'b0;
        end
    end

endmodule

/* source/sha256Compress.sv */
`timescale 1ns/10ps

module sha256Compress (
    input  logic             clock,
    input  logic             rstN,
    input  logic             mineTick,
    input  logic             blockStart,
    input  sha256Pkg::blockT block,
    input  sha256Pkg::stateT chainIn,
    output logic             blockDone,
    output sha256Pkg::stateT chainOut
);
    import sha256Pkg::*;

    // Control
    logic       active;
    logic       feedForward;
    logic [5:0] round;

    // Working variables a..h, index 0 is a
    stateT work;
    // Chain value kept for the final addition
    stateT savedChain;
    // Schedule window, word 0 is W[t]
    blockT window;

    // Round terms
    wordT t1;
    wordT t2;
    // W[t+16] for the window tail
    wordT nextWord;

    // h + S1(e) + ch(e,f,g) + K[t] + W[t]
    assign t1 = work[7] + bigSigma1(work[4]) + choose(work[4], work[5], work[6])
              + roundConst[round] + window[0];

    // S0(a) + maj(a,b,c)
    assign t2 = bigSigma0(work[0]) + majority(work[0], work[1], work[2]);

    // s1(W[t+14]) + W[t+9] + s0(W[t+1]) + W[t]
    // Extended every round, the last 16 results are never read
    assign nextWord = smallSigma1(window[14]) + window[9]
                    + smallSigma0(window[1]) + window[0];

    // Sequencing of load, 64 rounds, feed-forward
    always_ff @(posedge clock) begin
        if (!rstN) begin
            active <= 1'b0;
            feedForward <= 1'b0;
            round <= '0;
            blockDone <= 1'b0;
        end else if (mineTick) begin
            // Done lasts a single tick
            blockDone <= 1'b0;
            if (blockStart) begin
                active <= 1'b1;
                feedForward <= 1'b0;
                round <= '0;
            end else if (active) begin
                round <= round + 6'd1;
                // Round 63 is the last one
                if (round == 6'd63) begin
                    active <= 1'b0;
                    feedForward <= 1'b1;
                end
            end else if (feedForward) begin
                feedForward <= 1'b0;
                blockDone <= 1'b1;
            end
        end
    end

    // Datapath, follows the control flags above
    always_ff @(posedge clock) begin
        if (mineTick) begin
            if (blockStart) begin
                work <= chainIn;
                savedChain <= chainIn;
                window <= block;
            end else if (active) begin
                // a gets t1+t2, e gets d+t1, rest shift down one
                work <= {t1 + t2, work[0:2], work[3] + t1, work[4:6]};
                // Window slides by one word
                window <= {window[1:15], nextWord};
            end else if (feedForward) begin
                // Add compressed state back onto the input chain
                for (int i = 0; i < 8; i++) begin
                    chainOut[i] <= savedChain[i] + work[i];
                end
            end
        end
    end

endmodule

/* source/doubleHashSequencer.sv */
`timescale 1ns/10ps

module doubleHashSequencer (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic                   mineTick,
    input  logic                   hashStart,
    input  minerPkg::headerPrefixT headerPrefix,
    input  minerPkg::nonceT        nonce,
    input  logic                   blockDone,
    input  sha256Pkg::stateT       chainOut,
    output logic                   hashDone,
    output minerPkg::hashT         digest,
    output logic                   blockStart,
    output sha256Pkg::blockT       block,
    output sha256Pkg::stateT       chainIn
);
    import minerPkg::*;
    import sha256Pkg::*;

    // Which compression is running
    typedef enum logic [1:0] {
        seqIdle,
        seqFirst,
        seqSecond,
        seqOuter
    } seqStateT;

    seqStateT state;

    // The three message blocks
    blockT firstBlock;
    blockT secondBlock;
    blockT outerBlock;

    // Header bytes 0 to 63
    assign firstBlock = headerPrefix[headerPrefixBits-1 -: $bits(blockT)];

    // Bytes 64 to 75, nonce, 0x80, 39 zero bytes, 640 bit length
    assign secondBlock = {
        headerPrefix[headerPrefixBits-$bits(blockT)-1:0],
        nonce,
        8'h80,
        312'd0,
        64'(headerPrefixBits + nonceBits)
    };

    // Inner digest, 0x80, 23 zero bytes, 256 bit length
    assign outerBlock = {chainOut, 8'h80, 184'd0, 64'(hashBits)};

    // One blockStart per block, next one only after blockDone
    always_ff @(posedge clock) begin
        if (!rstN) begin
            state <= seqIdle;
            blockStart <= 1'b0;
            hashDone <= 1'b0;
        end else if (mineTick) begin
            // Both pulses are single tick
            blockStart <= 1'b0;
            hashDone <= 1'b0;
            case (state)
                seqIdle: begin
                    if (hashStart) begin
                        state <= seqFirst;
                        blockStart <= 1'b1;
                    end
                end
                seqFirst: begin
                    if (blockDone) begin
                        state <= seqSecond;
                        blockStart <= 1'b1;
                    end
                end
                seqSecond: begin
                    if (blockDone) begin
                        state <= seqOuter;
                        blockStart <= 1'b1;
                    end
                end
                seqOuter: begin
                    if (blockDone) begin
                        state <= seqIdle;
                        hashDone <= 1'b1;
                    end
                end
                default: state <= seqIdle;
            endcase
        end
    end

    // Block, chain and digest are loaded alongside the FSM steps
    always_ff @(posedge clock) begin
        if (mineTick) begin
            case (state)
                seqIdle: begin
                    if (hashStart) begin
                        block <= firstBlock;
                        chainIn <= initialState;
                    end
                end
                seqFirst: begin
                    // Second block continues the inner chain
                    if (blockDone) begin
                        block <= secondBlock;
                        chainIn <= chainOut;
                    end
                end
                seqSecond: begin
                    // Outer hash restarts from the IV
                    if (blockDone) begin
                        block <= outerBlock;
                        chainIn <= initialState;
                    end
                end
                seqOuter: begin
                    if (blockDone) begin
                        digest <= chainOut;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* source/nonceSearch.sv */
`timescale 1ns/10ps

module nonceSearch (
    input  logic            clock,
    input  logic            rstN,
    input  logic            mineTick,
    input  logic            start,
    input  minerPkg::nonceT nonceFirst,
    input  minerPkg::nonceT nonceLast,
    input  minerPkg::hashT  target,
    input  logic            hashDone,
    input  minerPkg::hashT  digest,
    output logic            hashStart,
    output minerPkg::nonceT nonce,
    output logic            busy,
    output logic            found,
    output logic            exhausted,
    output minerPkg::nonceT foundNonce,
    output minerPkg::hashT  foundHash,
    output logic            led
);
    import minerPkg::*;

    // Start seen, run begins on the next tick
    logic startPending;
    // Digest as a little endian number
    hashT digestNumber;
    logic hit;

    // Reverse the 32 bytes
    always_comb begin
        for (int i = 0; i < hashBits / 8; i++) begin
            digestNumber[8*i +: 8] = digest[hashBits - 8 - 8*i +: 8];
        end
    end

    assign hit = (digestNumber <= target);

    always_ff @(posedge clock) begin
        if (!rstN) begin
            busy <= 1'b0;
            startPending <= 1'b0;
            hashStart <= 1'b0;
            found <= 1'b0;
            exhausted <= 1'b0;
            led <= 1'b0;
            nonce <= '0;
            foundNonce <= '0;
            foundHash <= '0;
        end else begin
            // Start is caught on any clock, dropped while busy
            if (start && !busy) begin
                busy <= 1'b1;
                startPending <= 1'b1;
            end
            if (mineTick) begin
                hashStart <= 1'b0;
                if (startPending) begin
                    // Fresh run, old results go away
                    startPending <= 1'b0;
                    found <= 1'b0;
                    exhausted <= 1'b0;
                    led <= 1'b0;
                    foundNonce <= '0;
                    foundHash <= '0;
                    nonce <= nonceFirst;
                    hashStart <= 1'b1;
                end else if (busy && hashDone) begin
                    if (hit) begin
                        // First qualifying nonce wins
                        busy <= 1'b0;
                        found <= 1'b1;
                        led <= 1'b1;
                        foundNonce <= nonce;
                        foundHash <= digest;
                    end else if (nonce == nonceLast) begin
                        busy <= 1'b0;
                        exhausted <= 1'b1;
                    end else begin
                        nonce <= nonce + nonceT'(1);
                        hashStart <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* source/minerTop.sv */
`timescale 1ns/10ps

module minerTop (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic                   start,
    input  minerPkg::headerPrefixT headerPrefix,
    input  minerPkg::nonceT        nonceFirst,
    input  minerPkg::nonceT        nonceLast,
    input  minerPkg::hashT         target,
    output logic                   busy,
    output logic                   found,
    output logic                   exhausted,
    output minerPkg::nonceT        foundNonce,
    output minerPkg::hashT         foundHash,
    output logic                   led
);
    import minerPkg::*;
    import sha256Pkg::*;

    // Mining strobe, shared by all blocks
    logic mineTick;

    // Search to sequencer
    logic  hashStart;
    nonceT nonce;
    logic  hashDone;
    hashT  digest;

    // Sequencer to compressor
    logic  blockStart;
    blockT block;
    stateT chainIn;
    logic  blockDone;
    stateT chainOut;

    mineTickGen mineTickGen_i (
        .clock    (clock),
        .rstN     (rstN),
        .mineTick (mineTick)
    );

    nonceSearch nonceSearch_i (
        .clock      (clock),
        .rstN       (rstN),
        .mineTick   (mineTick),
        .start      (start),
        .nonceFirst (nonceFirst),
        .nonceLast  (nonceLast),
        .target     (target),
        .hashDone   (hashDone),
        .digest     (digest),
        .hashStart  (hashStart),
        .nonce      (nonce),
        .busy       (busy),
        .found      (found),
        .exhausted  (exhausted),
        .foundNonce (foundNonce),
        .foundHash  (foundHash),
        .led        (led)
    );

    doubleHashSequencer doubleHashSequencer_i (
        .clock        (clock),
        .rstN         (rstN),
        .mineTick     (mineTick),
        .hashStart    (hashStart),
        .headerPrefix (headerPrefix),
        .nonce        (nonce),
        .blockDone    (blockDone),
        .chainOut     (chainOut),
        .hashDone     (hashDone),
        .digest       (digest),
        .blockStart   (blockStart),
        .block        (block),
        .chainIn      (chainIn)
    );

    sha256Compress sha256Compress_i (
        .clock      (clock),
        .rstN       (rstN),
        .mineTick   (mineTick),
        .blockStart (blockStart),
        .block      (block),
        .chainIn    (chainIn),
        .blockDone  (blockDone),
        .chainOut   (chainOut)
    );

endmodule

/* dv/sha256Model.svh */
`ifndef SHA256_MODEL_SVH
`define SHA256_MODEL_SVH

// Reference SHA-256 written straight from the standard
// Expects minerPkg and sha256Pkg imported by the including module

function automatic wordT rotateRight(input wordT x, input int n);
    return (x >> n) | (x << (32 - n));
endfunction

// One 512 bit block on top of a chain value
function automatic stateT compressBlock(input stateT chain, input blockT blk);
    wordT w [0:63];
    wordT a, b, c, d, e, f, g, h;
    wordT s0, s1, t1, t2;
    // Full 64 word schedule up front
    for (int t = 0; t < 16; t++) begin
        w[t] = blk[t];
    end
    for (int t = 16; t < 64; t++) begin
        s0 = rotateRight(w[t-15], 7) ^ rotateRight(w[t-15], 18) ^ (w[t-15] >> 3);
        s1 = rotateRight(w[t-2], 17) ^ rotateRight(w[t-2], 19) ^ (w[t-2] >> 10);
        w[t] = w[t-16] + s0 + w[t-7] + s1;
    end
    a = chain[0];
    b = chain[1];
    c = chain[2];
    d = chain[3];
    e = chain[4];
    f = chain[5];
    g = chain[6];
    h = chain[7];
    for (int t = 0; t < 64; t++) begin
        s1 = rotateRight(e, 6) ^ rotateRight(e, 11) ^ rotateRight(e, 25);
        t1 = h + s1 + ((e & f) ^ (~e & g)) + roundConst[t] + w[t];
        s0 = rotateRight(a, 2) ^ rotateRight(a, 13) ^ rotateRight(a, 22);
        t2 = s0 + ((a & b) ^ (a & c) ^ (b & c));
        h = g;
        g = f;
        f = e;
        e = d + t1;
        d = c;
        c = b;
        b = a;
        a = t1 + t2;
    end
    return {a + chain[0], b + chain[1], c + chain[2], d + chain[3],
            e + chain[4], f + chain[5], g + chain[6], h + chain[7]};
endfunction

// SHA-256 of SHA-256 over the 80 byte header
function automatic hashT doubleHash(input headerPrefixT prefix, input nonceT nonceValue);
    stateT inner;
    blockT tail;
    blockT outer;
    inner = compressBlock(initialState, prefix[607 -: 512]);
    // Bytes 64 to 79, then 0x80, zeros, length 640
    tail = {prefix[95:0], nonceValue, 8'h80, 312'd0, 64'd640};
    inner = compressBlock(inner, tail);
    // 32 byte message, length 256
    outer = {inner, 8'h80, 184'd0, 64'd256};
    return compressBlock(initialState, outer);
endfunction

// Byte 31 of the digest becomes the top byte
function automatic hashT reverseBytes(input hashT h);
    hashT r;
    for (int i = 0; i < 32; i++) begin
        r[8*i +: 8] = h[255 - 8*i -: 8];
    end
    return r;
endfunction

// First nonce of the range at or under the target
task automatic findFirstHit(input headerPrefixT prefix, input nonceT first,
                            input nonceT last, input hashT goal, output logic hit,
                            output nonceT hitNonce, output hashT hitHash);
    nonceT n;
    hashT h;
    logic done;
    hit = 1'b0;
    hitNonce = '0;
    hitHash = '0;
    done = 1'b0;
    n = first;
    while (!done) begin
        h = doubleHash(prefix, n);
        if (reverseBytes(h) <= goal) begin
            hit = 1'b1;
            hitNonce = n;
            hitHash = h;
            done = 1'b1;
        end else if (n == last) begin
            done = 1'b1;
        end else begin
            n = n + 32'd1;
        end
    end
endtask

`endif

/* dv/minerTb.sv */
`timescale 1ns/10ps

module minerTb;
    import minerPkg::*;
    import sha256Pkg::*;

    `include "sha256Model.svh"

    // One search run per row
    // expectFound is what the target forces
    typedef struct packed {
        logic  randomHeader;
        nonceT nonceFirst;
        nonceT nonceLast;
        hashT  target;
        logic  retryStart;
        logic  expectFound;
    } stimT;

    localparam int numRuns = 5;
    localparam hashT allOnes = '1;
    localparam hashT zeroTarget = '0;
    // 32 leading zero bits
    localparam hashT lead32 = {32'h0, {224{1'b1}}};
    // Second start comes after the first full hash
    localparam int retryDelay = mineDivide * 250;
    // 198 hash ticks per nonce plus a few for search control
    localparam int ticksPerNonce = 206;

    // Block 125552 header without its nonce
    localparam headerPrefixT fixedHeader = {
        32'h01000000, 32'h81cd02ab, 32'h7e569e8b, 32'hcd9317e2, 32'hfe99f2de,
        32'h44d49ab2, 32'hb8851ba4, 32'ha3080000, 32'h00000000, 32'he320b6c2,
        32'hfffc8d75, 32'h0423db8b, 32'h1eb942ae, 32'h710e951e, 32'hd797f7af,
        32'hfc8892b0, 32'hf1fc122b, 32'hc7f5d74d, 32'hf2b9441a
    };

    stimT stimTable [0:numRuns-1];

    logic         clock;
    logic         rstN;
    logic         start;
    headerPrefixT headerPrefix;
    nonceT        nonceFirst;
    nonceT        nonceLast;
    hashT         target;
    logic         busy;
    logic         found;
    logic         exhausted;
    nonceT        foundNonce;
    hashT         foundHash;
    logic         led;

    int cycleCount;
    int cycleLimit;

    minerTop minerTop_i (
        .clock        (clock),
        .rstN         (rstN),
        .start        (start),
        .headerPrefix (headerPrefix),
        .nonceFirst   (nonceFirst),
        .nonceLast    (nonceLast),
        .target       (target),
        .busy         (busy),
        .found        (found),
        .exhausted    (exhausted),
        .foundNonce   (foundNonce),
        .foundHash    (foundHash),
        .led          (led)
    );

    // 10 ns period
    always #5 clock = ~clock;

    // Watchdog on the whole run
    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: search did not finish within %0d cycles", cycleLimit);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    task automatic failRun();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic checkHash(input string signalName, input hashT actual, input hashT expected);
        if (actual !== expected) begin
            $display("mismatch %s: got %h, expected %h", signalName, actual, expected);
            failRun();
        end
    endtask

    task automatic checkNonce(input string signalName, input nonceT actual,
                              input nonceT expected);
        if (actual !== expected) begin
            $display("mismatch %s: got %h, expected %h", signalName, actual, expected);
            failRun();
        end
    endtask

    task automatic checkFlag(input string signalName, input bit actual, input bit expected);
        if (actual !== expected) begin
            $display("mismatch %s: got %h, expected %h", signalName, actual, expected);
            failRun();
        end
    endtask

    // Columns are header, first, last, target, retry, expectFound
    task automatic fillTable();
        stimTable[0] = '{1'b1, 32'h0000_1000, 32'h0000_1003, allOnes, 1'b0, 1'b1};
        stimTable[1] = '{1'b0, 32'h42a1_4690, 32'h42a1_4698, lead32, 1'b1, 1'b1};
        stimTable[2] = '{1'b1, 32'h0000_0010, 32'h0000_0013, zeroTarget, 1'b0, 1'b0};
        stimTable[3] = '{1'b1, 32'hffff_fffd, 32'hffff_ffff, zeroTarget, 1'b1, 1'b0};
        stimTable[4] = '{1'b1, 32'h1234_5678, 32'h1234_567a, allOnes, 1'b0, 1'b1};
    endtask

    function automatic int totalNonces();
        int sum;
        sum = 0;
        for (int r = 0; r < numRuns; r++) begin
            sum += int'(stimTable[r].nonceLast - stimTable[r].nonceFirst) + 1;
        end
        return sum;
    endfunction

    function automatic headerPrefixT randomPrefix();
        headerPrefixT p;
        for (int i = 0; i < headerPrefixBits / 32; i++) begin
            p[32*i +: 32] = $urandom();
        end
        return p;
    endfunction

    // Start pulse then wait for busy to fall
    task automatic runSearch(input stimT stim, input headerPrefixT prefix,
                             output logic sawClear, output int busyCycles);
        @(posedge clock);
        headerPrefix <= prefix;
        nonceFirst <= stim.nonceFirst;
        nonceLast <= stim.nonceLast;
        target <= stim.target;
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        sawClear = 1'b0;
        busyCycles = 0;
        do @(negedge clock); while (!busy);
        while (busy) begin
            // Old results must drop at some point while busy
            if (!found && !led && !exhausted) begin
                sawClear = 1'b1;
            end
            // Second start lands mid search and must be ignored
            if (stim.retryStart && busyCycles == retryDelay) begin
                @(posedge clock);
                start <= 1'b1;
                @(posedge clock);
                start <= 1'b0;
                busyCycles++;
            end
            @(negedge clock);
            busyCycles++;
        end
    endtask

    initial begin
        headerPrefixT prefix;
        logic         hit;
        nonceT        hitNonce;
        hashT         hitHash;
        logic         sawClear;
        int           busyCycles;
        int           tried;
        void'($urandom(32'h2b2b_dbdc));
        fillTable();
        // About 200 ticks of 3 clocks per nonce
        cycleLimit = 3 * 200 * totalNonces() + 2000;
        cycleCount = 0;
        clock = 1'b0;
        rstN = 1'b0;
        start = 1'b0;
        headerPrefix = '0;
        nonceFirst = '0;
        nonceLast = '0;
        target = '0;
        repeat (10) @(posedge clock);
        rstN <= 1'b1;
        @(negedge clock);
        // Idle outputs straight out of reset
        checkFlag("busy", busy, 1'b0);
        checkFlag("found", found, 1'b0);
        checkFlag("exhausted", exhausted, 1'b0);
        checkFlag("led", led, 1'b0);
        checkNonce("foundNonce", foundNonce, nonceT'(0));
        checkHash("foundHash", foundHash, hashT'(0));
        for (int r = 0; r < numRuns; r++) begin
            prefix = stimTable[r].randomHeader ? randomPrefix() : fixedHeader;
            findFirstHit(prefix, stimTable[r].nonceFirst, stimTable[r].nonceLast,
                         stimTable[r].target, hit, hitNonce, hitHash);
            if (hit !== stimTable[r].expectFound) begin
                $display("reference model and stimulus table disagree on run %0d", r);
                failRun();
            end
            // Known answer for the real block
            if (!stimTable[r].randomHeader) begin
                checkNonce("model nonce for block 125552", hitNonce, 32'h42a1_4695);
            end
            runSearch(stimTable[r], prefix, sawClear, busyCycles);
            checkFlag("found", found, hit);
            checkFlag("led", led, hit);
            checkFlag("exhausted", exhausted, !hit);
            checkNonce("foundNonce", foundNonce, hit ? hitNonce : nonceT'(0));
            checkHash("foundHash", foundHash, hit ? hitHash : hashT'(0));
            if (!sawClear) begin
                $display("run %0d kept the previous results set for the whole search", r);
                failRun();
            end
            // Nonces the search had to hash
            if (hit) begin
                tried = int'(hitNonce - stimTable[r].nonceFirst) + 1;
            end else begin
                tried = int'(stimTable[r].nonceLast - stimTable[r].nonceFirst) + 1;
            end
            if (busyCycles > tried * mineDivide * ticksPerNonce) begin
                $display("run %0d stayed busy for %0d cycles, too long for %0d nonces",
                         r, busyCycles, tried);
                failRun();
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* compile.f */
+incdir+dv
source/minerPkg.sv
source/sha256Pkg.sv
source/mineTickGen.sv
source/sha256Compress.sv
source/doubleHashSequencer.sv
source/nonceSearch.sv
source/minerTop.sv
dv/minerTb.sv

/* Makefile */
# Verilator build and run of the miner testbench

VERILATOR ?= verilator
TOP       ?= minerTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^NO ERRORS$$" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
